// File: hdl/aer_link_pkg.sv
// shared widths and types for the aer to spinnaker bridge; packet layout fixed at 40 bits, no payload
package aer_link_pkg;

  // ------------------------------------------------
  // widths and constants
  // ------------------------------------------------
  localparam int AER_W      = 16;  // sensor word
  localparam int COORD_W    = 15;  // mapped coordinate field
  localparam int PKT_W      = 40;  // spinnaker packet
  localparam int NIBBLES    = 10;  // data symbols per packet
  localparam int SYM_W      = 7;   // 2-of-7 link wires
  localparam int STALL_BITS = 5;   // watchdog counter
  localparam int SYM_CNT_W  = 4;   // symbol counter, counts up to NIBBLES

  localparam logic [15:0] CHIP_ADDR_DEF = 16'h0200;  // default virtual chip
  localparam logic [15:0] CHIP_ADDR_ALT = 16'hfefe;  // alternate virtual chip

  // ------------------------------------------------
  // mode select
  // ------------------------------------------------
  typedef enum logic [2:0] {
    FMT_RET128  = 3'd0,
    FMT_RET64   = 3'd1,
    FMT_RET32   = 3'd2,
    FMT_RET16   = 3'd3,
    FMT_COCHLEA = 3'd4,
    FMT_DIRECT  = 3'd5
  } fmt_e;

  typedef struct packed {
    logic alt;  // use alternate chip address
    fmt_e fmt;
  } mode_s;

  // ------------------------------------------------
  // sensor word views
  // ------------------------------------------------
  typedef struct packed {
    logic       kind;
    logic [6:0] y;
    logic [6:0] x;
    logic       pol;   // polarity
  } retina_s;

  typedef struct packed {
    logic       kind;
    logic [4:0] unused;
    logic [1:0] chan_lo;
    logic [5:0] chan_hi;
    logic       ear;
    logic       spare;
  } cochlea_s;

  // same word, decoded as retina or cochlea depending on the mode
  typedef union packed {
    retina_s          retina;
    cochlea_s         cochlea;
    logic [AER_W-1:0] bits;
  } aer_word_u;

  // nibble 0 is {routing, parity}, sent first
  typedef struct packed {
    logic [15:0]        chip_addr;
    logic               kind;
    logic [COORD_W-1:0] coords;
    logic [3:0]         payload_hi;
    logic [2:0]         routing;
    logic               parity;     // makes packet odd parity
  } spinn_pkt_s;

  typedef struct packed {
    logic busy;      // packet on the link
    logic ack_edge;  // one cycle per synchronised ack transition
  } link_status_s;

  // ------------------------------------------------
  // 2-of-7 change pattern for a symbol value
  // ------------------------------------------------
  function automatic logic [SYM_W-1:0] sym_2of7(input logic [4:0] val);
    logic [SYM_W-1:0] pat;
    casez (val)
      5'b00000: pat = 7'b0010001;
      5'b00001: pat = 7'b0010010;
      5'b00010: pat = 7'b0010100;
      5'b00011: pat = 7'b0011000;
      5'b00100: pat = 7'b0100001;
      5'b00101: pat = 7'b0100010;
      5'b00110: pat = 7'b0100100;
      5'b00111: pat = 7'b0101000;
      5'b01000: pat = 7'b1000001;
      5'b01001: pat = 7'b1000010;
      5'b01010: pat = 7'b1000100;
      5'b01011: pat = 7'b1001000;
      5'b01100: pat = 7'b0000011;
      5'b01101: pat = 7'b0000110;
      5'b01110: pat = 7'b0001100;
      5'b01111: pat = 7'b0001001;
      default:  pat = 7'b1100000;  // end of packet, bit 4 set
    endcase
    return pat;
  endfunction

endpackage

// File: hdl/aer_event_mapper.sv
// purely combinational; mode must be stable when the transmitter captures, fmt codes 6 and 7 map as retina 128
module aer_event_mapper import aer_link_pkg::*; (
  input  aer_word_u  i_aer_data,
  input  mode_s      i_mode,
  output spinn_pkt_s o_pkt
);

  logic [6:0]         rot_x;   // 90 degree rotated x
  logic [6:0]         rot_y;   // 90 degree rotated y
  logic [COORD_W-1:0] coords;
  spinn_pkt_s         body;    // packet before parity

  // ------------------------------------------------
  // retina rotation
  // ------------------------------------------------
  assign rot_x = 7'd127 - i_aer_data.retina.y;  // new x = 127 - old y
  assign rot_y = 7'd127 - i_aer_data.retina.x;  // new y = 127 - old x

  // ------------------------------------------------
  // coordinate field per format
  // ------------------------------------------------
  always_comb
  begin
    case (i_mode.fmt)
      FMT_RET64:
        coords = {i_aer_data.retina.pol, 2'b00, rot_y[6:1], rot_x[6:1]};
      FMT_RET32:
        coords = {i_aer_data.retina.pol, 4'b0000, rot_y[6:2], rot_x[6:2]};
      FMT_RET16:
        coords = {i_aer_data.retina.pol, 6'b000000, rot_y[6:3], rot_x[6:3]};
      FMT_COCHLEA:  // ear up at bit 11, channel at the bottom
        coords = {3'b000, i_aer_data.cochlea.ear, 3'b000,
                  i_aer_data.cochlea.chan_hi, i_aer_data.cochlea.chan_lo};
      FMT_DIRECT:
        coords = i_aer_data.bits[COORD_W-1:0];  // raw pass-through
      default:      // retina 128, full resolution
        coords = {i_aer_data.retina.pol, rot_y, rot_x};
    endcase
  end

  // ------------------------------------------------
  // packet assembly
  // ------------------------------------------------
  always_comb
  begin
    body            = '0;
    body.chip_addr  = i_mode.alt ? CHIP_ADDR_ALT : CHIP_ADDR_DEF;
    body.kind       = i_aer_data.bits[AER_W-1];  // event type bit
    body.coords     = coords;
    body.payload_hi = 4'h0;  // no payload
    body.routing    = 3'b000;
  end

  // odd parity over the whole 40 bits
  assign o_pkt = {body[PKT_W-1:1], ~^body[PKT_W-1:1]};

endmodule

// File: hdl/link_watchdog.sv
// dump mode after 32 cycles with no link ack while busy; counter free runs and wraps
module link_watchdog import aer_link_pkg::*; (
  input  logic         clk,
  input  logic         debounce_reset,
  input  link_status_s i_status,
  output logic         o_dump_mode
);

  logic [STALL_BITS-1:0] stall_cnt;    // cycles since last ack
  logic                  dump_mode_r;

  // ------------------------------------------------
  // stall counter and dump flag
  // ------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (debounce_reset)
    begin
      stall_cnt   <= '0;
      dump_mode_r <= 1'b0;
    end
    else
    begin
      if (i_status.ack_edge)
        stall_cnt <= '0;  // link responded
      else
        stall_cnt <= stall_cnt + 1'b1;

      if (i_status.ack_edge)
        dump_mode_r <= 1'b0;                // leave on any ack
      else if ((&stall_cnt) && i_status.busy)
        dump_mode_r <= 1'b1;                // link stalled mid packet
    end
  end

  assign o_dump_mode = dump_mode_r;

  // dump mode only while the transmitter holds a packet on the link
  a_dump_needs_busy: assert property (@(posedge clk) disable iff (debounce_reset)
    dump_mode_r |-> i_status.busy);

endmodule

// File: hdl/spinn_link_tx.sv
// one packet in flight; waits forever on a silent link, the sensor is released only by dump mode
module spinn_link_tx import aer_link_pkg::*; (
  input  logic             clk,
  input  logic             debounce_reset,
  input  logic             i_aer_req,      // active low
  input  spinn_pkt_s       i_pkt,
  input  logic             i_link_ack,     // transition signalling
  input  logic             i_dump_mode,
  output logic [SYM_W-1:0] o_link_data,    // nrz 2-of-7
  output logic             o_aer_ack,      // active low
  output link_status_s     o_status
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_LOAD,
    ST_SEND,
    ST_WAIT,
    ST_DONE
  } tx_state_e;

  logic                 req_s1;
  logic                 req_s2;     // synchronised request
  logic                 ack_s1;
  logic                 ack_s2;     // synchronised link ack
  logic                 ack_s3;     // previous ack level
  logic                 ack_edge;
  tx_state_e            state;
  logic                 capture;
  logic                 next_nib;
  logic [PKT_W-1:0]     pkt_sr;     // nibble shifter
  logic [4:0]           nib_r;      // symbol to send, bit 4 = eop
  logic [SYM_CNT_W-1:0] sym_cnt;
  logic [SYM_W-1:0]     link_r;
  logic                 tx_ack_n;   // fsm wants to ack the sensor
  logic                 aer_ack_r;

  // ------------------------------------------------
  // synchronisers
  // ------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (debounce_reset)
    begin
      req_s1 <= 1'b1;  // request idle high
      req_s2 <= 1'b1;
    end
    else
    begin
      req_s1 <= i_aer_req;
      req_s2 <= req_s1;
    end
  end

  always_ff @(posedge clk)
  begin
    ack_s1 <= i_link_ack;
    ack_s2 <= ack_s1;
    ack_s3 <= ack_s2;
  end

  assign ack_edge = ack_s2 ^ ack_s3;  // either edge is one ack

  assign capture  = (state == ST_IDLE) && !req_s2 && !i_dump_mode;
  assign next_nib = (state == ST_LOAD) ||
                    ((state == ST_WAIT) && ack_edge && (sym_cnt != SYM_CNT_W'(NIBBLES)));

  // ------------------------------------------------
  // packet shifter
  // ------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (capture)
      pkt_sr <= i_pkt;                // mode sampled here
    else if (next_nib)
      pkt_sr <= pkt_sr >> 4;

    if (next_nib)
    begin
      if ((state == ST_WAIT) && (sym_cnt == SYM_CNT_W'(NIBBLES - 1)))
        nib_r <= {1'b1, 4'h0};        // eop after last nibble
      else
        nib_r <= {1'b0, pkt_sr[3:0]};
    end
  end

  // ------------------------------------------------
  // symbol sender fsm
  // ------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (debounce_reset)
    begin
      state    <= ST_IDLE;
      sym_cnt  <= '0;
      link_r   <= '0;
      tx_ack_n <= 1'b1;
    end
    else
    begin
      case (state)
        ST_IDLE:
          if (capture)
          begin
            sym_cnt <= '0;
            state   <= ST_LOAD;
          end
        ST_LOAD:
          state <= ST_SEND;                     // first nibble loading
        ST_SEND:
        begin
          link_r <= link_r ^ sym_2of7(nib_r);   // nrz toggle of two wires
          state  <= ST_WAIT;
        end
        ST_WAIT:
          if (ack_edge)
          begin
            if (sym_cnt == SYM_CNT_W'(NIBBLES))
            begin
              tx_ack_n <= 1'b0;                 // eop acked, release sensor
              state    <= ST_DONE;
            end
            else
            begin
              sym_cnt <= sym_cnt + 1'b1;
              state   <= ST_SEND;
            end
          end
        ST_DONE:
          if (req_s2)                           // sensor saw the ack
          begin
            tx_ack_n <= 1'b1;
            state    <= ST_IDLE;
          end
        default:
          state <= ST_IDLE;
      endcase
    end
  end

  // ------------------------------------------------
  // sensor ack
  // ------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (debounce_reset)
      aer_ack_r <= 1'b1;
    else if (i_dump_mode)
      aer_ack_r <= req_s2;             // ack everything, event dropped
    else
      aer_ack_r <= tx_ack_n | req_s2;  // only while a request is present
  end

  assign o_link_data       = link_r;
  assign o_aer_ack         = aer_ack_r;
  assign o_status.busy     = (state == ST_LOAD) || (state == ST_SEND) || (state == ST_WAIT);
  assign o_status.ack_edge = ack_edge;

  // each nrz symbol flips exactly two wires
  a_two_wires: assert property (@(posedge clk) disable iff (debounce_reset)
    (link_r != $past(link_r)) |-> ($countones(link_r ^ $past(link_r)) == 2));

endmodule

// File: hdl/aer_spinn_bridge.sv
// aer sensor to spinnaker 2-of-7 bridge; single clock, mode is a static level input
module aer_spinn_bridge import aer_link_pkg::*; (
  input  logic             clk,
  input  logic             debounce_reset,
  input  logic             i_aer_req,
  input  aer_word_u        i_aer_data,
  output logic             o_aer_ack,
  input  mode_s            i_mode,
  output logic [SYM_W-1:0] o_link_data,
  input  logic             i_link_ack,
  output logic             o_dump_mode
);

  spinn_pkt_s   pkt;          // mapped packet, live
  link_status_s link_status;
  logic         dump_mode;

  aer_event_mapper u_mapper (
    .i_aer_data (i_aer_data),
    .i_mode     (i_mode),
    .o_pkt      (pkt)
  );

  link_watchdog u_watchdog (
    .clk            (clk),
    .debounce_reset (debounce_reset),
    .i_status       (link_status),
    .o_dump_mode    (dump_mode)
  );

  spinn_link_tx u_tx (
    .clk            (clk),
    .debounce_reset (debounce_reset),
    .i_aer_req      (i_aer_req),
    .i_pkt          (pkt),
    .i_link_ack     (i_link_ack),
    .i_dump_mode    (dump_mode),
    .o_link_data    (o_link_data),
    .o_aer_ack      (o_aer_ack),
    .o_status       (link_status)
  );

  assign o_dump_mode = dump_mode;  // status out

endmodule

// File: tests/spinn_link_model.sv
// receiver model, one symbol in flight; more than ten data symbols in a packet count as bad
module spinn_link_model import aer_link_pkg::*; (
  input  logic             clk,
  input  logic             i_enable,     // low holds the ack back
  input  logic [SYM_W-1:0] i_link_data,
  output logic             o_link_ack,   // transition signalling
  output logic [PKT_W-1:0] o_pkt,        // last complete packet
  output logic             o_done,
  output int               o_syms,       // changes in current packet
  output int               o_acked,      // acks in current packet
  output int               o_pkts,
  output int               o_bad
);

  timeunit 1ns;
  timeprecision 1ps;

  logic [SYM_W-1:0] prev;       // wire levels before the change
  logic [PKT_W-1:0] assembled;
  logic             new_pkt;
  int               val;
  int               delay;

  // inverse of the 2-of-7 table, 16 = end of packet, -1 = not a symbol
  function automatic int decode_symbol(input logic [SYM_W-1:0] change);
    int found;
    found = -1;
    for (int v = 16; v >= 0; v--)
      if (sym_2of7(5'(v)) == change)
        found = v;
    return found;
  endfunction

  initial
  begin
    o_link_ack = 1'b0;
    o_pkt      = '0;
    o_done     = 1'b0;
    o_syms     = 0;
    o_acked    = 0;
    o_pkts     = 0;
    o_bad      = 0;
    prev       = '0;
    assembled  = '0;
    new_pkt    = 1'b1;
    forever
    begin
      @(posedge clk);
      #2;  // after the tb drive point
      if (i_link_data != prev)
      begin
        if (new_pkt)
        begin
          o_syms    = 0;
          o_acked   = 0;
          assembled = '0;
          new_pkt   = 1'b0;
        end
        val  = decode_symbol(i_link_data ^ prev);  // nrz, change is the symbol
        prev = i_link_data;
        o_syms++;
        if (val == 16)
        begin
          o_pkt   = assembled;
          o_pkts++;
          o_done  = 1'b1;
          new_pkt = 1'b1;
        end
        else if (val < 0 || o_syms > NIBBLES)
          o_bad++;
        else
          assembled[4*(o_syms-1) +: 4] = val[3:0];  // nibble 0 lowest
        delay = $urandom_range(6, 1);
        repeat (delay)
        begin
          @(posedge clk);
          #2;
          o_done = 1'b0;
        end
        while (!i_enable)  // silent link
        begin
          @(posedge clk);
          #2;
        end
        o_link_ack = ~o_link_ack;
        o_acked++;
      end
    end
  end

endmodule

// File: tests/tb_aer_spinn_bridge.sv
// needs the link model for acks; the silent row expects the watchdog to free the sensor
module tb_aer_spinn_bridge import aer_link_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  typedef struct packed {
    mode_s       mode;
    logic [15:0] word;
    logic        rnd;     // word replaced by $urandom
    logic        silent;  // link model held quiet
  } row_s;

  typedef enum int {
    C_ACK_LOW, C_ACK_HIGH, C_DUMP_HIGH, C_DUMP_LOW, C_LINK_MOVED, C_PKT_DONE, C_ALL_ACKED
  } cond_e;

  logic             clk;
  logic             debounce_reset;
  logic             aer_req;
  aer_word_u        aer_data;
  mode_s            mode;
  logic             aer_ack;
  logic [SYM_W-1:0] link_data;
  logic             link_ack;
  logic             dump_mode;
  logic             link_en;
  logic [PKT_W-1:0] link_pkt;
  logic             link_done;
  int               link_syms;
  int               link_acked;
  int               link_pkts;
  int               link_bad;
  logic [SYM_W-1:0] saved_link;   // link level before a row
  int               pkt_target;
  int               row_err;
  int               rows_ok;
  int               rows_bad;
  bit               timed_out;

  // ------------------------------------------------
  // stimulus table
  // ------------------------------------------------
  row_s rows [10] = '{
    '{'{1'b0, FMT_RET128},  16'h8a35, 1'b0, 1'b0},
    '{'{1'b0, FMT_RET128},  16'h0000, 1'b1, 1'b0},
    '{'{1'b0, FMT_RET64},   16'h3c7e, 1'b0, 1'b0},
    '{'{1'b0, FMT_RET32},   16'h0000, 1'b1, 1'b0},
    '{'{1'b0, FMT_RET16},   16'hffff, 1'b0, 1'b0},
    '{'{1'b1, FMT_COCHLEA}, 16'h83ad, 1'b0, 1'b0},
    '{'{1'b1, FMT_COCHLEA}, 16'h0000, 1'b1, 1'b0},
    '{'{1'b1, FMT_DIRECT},  16'h5aa5, 1'b0, 1'b0},
    '{'{1'b0, FMT_RET128},  16'h1234, 1'b0, 1'b1},  // stalls the link
    '{'{1'b1, FMT_DIRECT},  16'h0000, 1'b1, 1'b0}   // after recovery
  };

  aer_spinn_bridge dut (
    .clk            (clk),
    .debounce_reset (debounce_reset),
    .i_aer_req      (aer_req),
    .i_aer_data     (aer_data),
    .o_aer_ack      (aer_ack),
    .i_mode         (mode),
    .o_link_data    (link_data),
    .i_link_ack     (link_ack),
    .o_dump_mode    (dump_mode)
  );

  spinn_link_model u_link (
    .clk         (clk),
    .i_enable    (link_en),
    .i_link_data (link_data),
    .o_link_ack  (link_ack),
    .o_pkt       (link_pkt),
    .o_done      (link_done),
    .o_syms      (link_syms),
    .o_acked     (link_acked),
    .o_pkts      (link_pkts),
    .o_bad       (link_bad)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // 4 ns period
  end

  // ------------------------------------------------
  // expected packet from the mapping rules
  // ------------------------------------------------
  function automatic logic [PKT_W-1:0] expected_packet(input mode_s m, input logic [15:0] w);
    logic [6:0]       nx;
    logic [6:0]       ny;
    logic [14:0]      c;
    logic [PKT_W-1:0] p;
    int               sh;
    nx = 7'd127 - w[14:8];  // new x from old y
    ny = 7'd127 - w[7:1];   // new y from old x
    c  = '0;
    case (m.fmt)
      FMT_COCHLEA:
      begin
        c[11]  = w[1];                // ear
        c[7:0] = {w[7:2], w[9:8]};
      end
      FMT_DIRECT:
        c = w[14:0];
      default:
      begin
        sh = (m.fmt == FMT_RET64) ? 1 : (m.fmt == FMT_RET32) ? 2 : (m.fmt == FMT_RET16) ? 3 : 0;
        c = (15'(ny >> sh) << (7 - sh)) | 15'(nx >> sh);  // scaled y above scaled x
        c[14] = w[0];                                     // polarity on top
      end
    endcase
    p    = {(m.alt ? 16'hfefe : 16'h0200), w[15], c, 4'h0, 3'b000, 1'b0};
    p[0] = ($countones(p) % 2) == 0;  // odd parity over 40 bits
    return p;
  endfunction

  function automatic bit condition_holds(input cond_e c);
    case (c)
      C_ACK_LOW:    return aer_ack == 1'b0;
      C_ACK_HIGH:   return aer_ack == 1'b1;
      C_DUMP_HIGH:  return dump_mode == 1'b1;
      C_DUMP_LOW:   return dump_mode == 1'b0;
      C_LINK_MOVED: return link_data != saved_link;
      C_PKT_DONE:   return link_done == 1'b1;
      default:      return link_acked == 11;
    endcase
  endfunction

  task automatic wait_until(input cond_e c, input int limit, input string what);
    int  n;
    bit  seen;
    seen = 1'b0;
    for (n = 0; n < limit && !seen; n++)
    begin
      @(posedge clk);
      seen = condition_holds(c);
    end
    if (!seen)
    begin
      $display("timeout at t=%0t: %s did not happen within %0d cycles", $time, what, limit);
      timed_out = 1'b1;
    end
  endtask

  task automatic report_mismatch(input string name, input logic [PKT_W-1:0] exp,
                                 input logic [PKT_W-1:0] act);
    $display("FAILED t=%0t %s expected %h got %h", $time, name, exp, act);
    row_err++;
  endtask

  task automatic start_request(input mode_s m, input logic [15:0] w);
    @(posedge clk);
    #1;
    mode          = m;
    aer_data.bits = w;
    aer_req       = 1'b0;  // active low
  endtask

  task automatic end_request();
    @(posedge clk);
    #1 aer_req = 1'b1;
  endtask

  task automatic run_normal_row(input mode_s m, input logic [15:0] w, input logic [PKT_W-1:0] exp);
    pkt_target = link_pkts + 1;
    start_request(m, w);
    wait_until(C_ACK_LOW, 400, "o_aer_ack falling after the packet");
    if (timed_out)
      return;
    if (link_acked != 11)  // ack only after the eop ack
      report_mismatch("link acks before o_aer_ack fell", 40'd11, 40'(link_acked));
    if (link_syms != 11)
      report_mismatch("o_link_data changes in packet", 40'd11, 40'(link_syms));
    if (link_pkts != pkt_target)
      report_mismatch("end-of-packet count", 40'(pkt_target), 40'(link_pkts));
    if (link_pkt !== exp)
      report_mismatch("decoded packet", exp, link_pkt);
    end_request();
    wait_until(C_ACK_HIGH, 20, "o_aer_ack rising after request release");
  endtask

  task automatic run_silent_row(input mode_s m, input logic [15:0] w, input logic [PKT_W-1:0] exp);
    pkt_target = link_pkts + 1;
    saved_link = link_data;
    @(posedge clk);
    #1 link_en = 1'b0;
    start_request(m, w);
    wait_until(C_LINK_MOVED, 50, "first symbol on o_link_data");
    if (timed_out)
      return;
    wait_until(C_DUMP_HIGH, 40, "o_dump_mode rising on the stalled link");
    if (timed_out)
      return;
    for (int k = 0; k < 3; k++)  // stalled request, then two dropped events
    begin
      if (k > 0)
        start_request(m, 16'($urandom));
      wait_until(C_ACK_LOW, 20, "o_aer_ack falling in dump mode");
      if (timed_out)
        return;
      end_request();
      wait_until(C_ACK_HIGH, 20, "o_aer_ack rising in dump mode");
      if (timed_out)
        return;
    end
    @(posedge clk);
    #1 link_en = 1'b1;
    wait_until(C_DUMP_LOW, 40, "o_dump_mode falling after a link ack");
    if (timed_out)
      return;
    wait_until(C_PKT_DONE, 400, "held packet finishing on the link");
    if (timed_out)
      return;
    if (link_pkts != pkt_target)
      report_mismatch("end-of-packet count", 40'(pkt_target), 40'(link_pkts));
    if (link_syms != 11)
      report_mismatch("o_link_data changes in packet", 40'd11, 40'(link_syms));
    if (link_pkt !== exp)
      report_mismatch("decoded held packet", exp, link_pkt);
    wait_until(C_ALL_ACKED, 20, "final link ack of the held packet");
    repeat (6) @(posedge clk);  // ack sync and fsm back to idle
  endtask

  task automatic tally_row(input string name);
    if (row_err == 0 && !timed_out)
    begin
      rows_ok++;
      $display("ok     %s", name);
    end
    else
    begin
      rows_bad++;
      $display("not ok %s", name);
    end
    row_err = 0;
  endtask

  // ------------------------------------------------
  // main sequence
  // ------------------------------------------------
  initial
  begin
    logic [15:0]      w;
    logic [PKT_W-1:0] exp;
    void'($urandom(32'he0ed_7943));
    debounce_reset = 1'b1;
    aer_req        = 1'b1;
    aer_data       = '0;
    mode           = '0;
    link_en        = 1'b1;
    saved_link     = '0;
    pkt_target     = 0;
    row_err        = 0;
    rows_ok        = 0;
    rows_bad       = 0;
    timed_out      = 1'b0;
    repeat (8) @(posedge clk);
    #1 debounce_reset = 1'b0;
    @(posedge clk);
    if (aer_ack !== 1'b1)
      report_mismatch("o_aer_ack", 40'd1, 40'(aer_ack));
    if (link_data !== '0)
      report_mismatch("o_link_data", 40'd0, 40'(link_data));
    if (dump_mode !== 1'b0)
      report_mismatch("o_dump_mode", 40'd0, 40'(dump_mode));
    tally_row("values after reset");
    for (int i = 0; i < 10 && !timed_out; i++)
    begin
      w   = rows[i].rnd ? 16'($urandom) : rows[i].word;
      exp = expected_packet(rows[i].mode, w);
      if (rows[i].silent)
        run_silent_row(rows[i].mode, w, exp);
      else
        run_normal_row(rows[i].mode, w, exp);
      tally_row($sformatf("row %0d fmt %0d word %h", i, rows[i].mode.fmt, w));
    end
    if (link_bad != 0)  // not a 2-of-7 change, or too many symbols
      report_mismatch("bad symbols on o_link_data", 40'd0, 40'(link_bad));
    tally_row("link symbol coding");
    $display("tests passed %0d, tests failed %0d", rows_ok, rows_bad);
    if (rows_bad == 0 && !timed_out)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule

// File: compile.f
hdl/aer_link_pkg.sv
hdl/aer_event_mapper.sv
hdl/link_watchdog.sv
hdl/spinn_link_tx.sv
hdl/aer_spinn_bridge.sv
tests/spinn_link_model.sv
tests/tb_aer_spinn_bridge.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 --top-module tb_aer_spinn_bridge -f compile.f -o tb_sim \
  && ./obj_dir/tb_sim | tee /dev/stderr | grep -F -q -- '*** PASSED ***' \
  && echo "simulation run ok" \
  || { echo "simulation run not ok"; exit 1; }
